/* common/gb_glue_pkg.sv */
// shared definitions for the handheld console glue logic
// register map, timing constants, FSM states and the bus, audio and video structs
// imported by every glue module that needs one of them

`default_nettype none

package gb_glue_pkg;

  //////////////////////////////
  // host register map

  // any write restarts the core reset hold
  localparam logic [31:0] ADDR_RESET_REQ = 32'h0000_0050;
  // bit 0 keeps audio playing during fast-forward
  localparam logic [31:0] ADDR_FF_SND    = 32'h0000_020C;
  localparam logic [31:0] ADDR_GRAY      = 32'h0000_0220;
  // 16 bits shifted in at the low end per write
  localparam logic [31:0] ADDR_PALETTE   = 32'h0000_0224;

  //////////////////////////////
  // timing

  // hardware runs about a million cycles, scaled down here
  localparam logic [31:0] RESET_HOLD_CYCLES = 32'd64;
  // button held for fewer cycles counts as a tap
  localparam logic [31:0] TAP_LIMIT         = 32'd32;
  // keeps hsync clear of the vsync pulse
  localparam logic [2:0]  HS_DELAY          = 3'd7;

  //////////////////////////////
  // types

  typedef enum logic [1:0] {
    FF_OFF,
    FF_HOLD,
    FF_LATCHED,
    FF_UNLATCH_HOLD
  } ff_state_e;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [31:0] addr;
    logic [31:0] wr_data;
  } bridge_req_t;

  typedef struct packed {
    logic ff_snd_en;
    logic gray_en;
  } host_cfg_t;

  // color 0 sits in the top bits
  typedef struct packed {
    logic [23:0] color0;
    logic [23:0] color1;
    logic [23:0] color2;
    logic [23:0] color3;
  } palette_t;

  typedef struct packed {
    logic signed [15:0] left;
    logic signed [15:0] right;
  } audio_sample_t;

  typedef struct packed {
    logic [1:0] shade;
    logic       hblank;
    logic       vblank;
    logic       hsync;
    logic       vsync;
  } lcd_in_t;

  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } video_t;

  localparam palette_t PALETTE_DEFAULT = 96'h828214_517356_305A5F_1A3B49;

endpackage

`default_nettype wire

/* design/fast_forward_ctrl.sv */
// fast-forward button handling and audio mute
// a short tap latches fast-forward on, a long hold runs it only while held
// audio is zeroed under fast-forward unless ff_snd_en is set

`default_nettype none

module fast_forward_ctrl
  import gb_glue_pkg::*;
(
  input  wire                clk_sys,
  input  wire                pll_core_locked,
  input  wire                ff_button,
  input  wire                ff_snd_en,
  input  wire audio_sample_t audio_in,
  output audio_sample_t      audio_out,
  output logic               fast_forward
);

  ff_state_e   state;
  logic [31:0] hold_cnt;

  //////////////////////////////
  // tap / hold FSM

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state    <= FF_OFF;
      hold_cnt <= 32'd0;
    end else begin
      case (state)
        FF_OFF: begin
          if (ff_button) begin
            state    <= FF_HOLD;
            hold_cnt <= 32'd0;
          end
        end
        FF_HOLD: begin
          if (!ff_button) begin
            // short press latches, long press just ends
            state <= (hold_cnt < TAP_LIMIT) ? FF_LATCHED : FF_OFF;
          end else if (hold_cnt < TAP_LIMIT) begin
            // saturate, only the compare matters
            hold_cnt <= hold_cnt + 32'd1;
          end
        end
        FF_LATCHED: begin
          if (ff_button) begin
            state <= FF_UNLATCH_HOLD;
          end
        end
        FF_UNLATCH_HOLD: begin
          if (!ff_button) begin
            state <= FF_OFF;
          end
        end
        default: state <= FF_OFF;
      endcase
    end
  end

  assign fast_forward = (state != FF_OFF);

  //////////////////////////////
  // audio register

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      audio_out <= '0;
    end else if (fast_forward && !ff_snd_en) begin
      audio_out <= '0;
    end else begin
      audio_out <= audio_in;
    end
  end

endmodule

`default_nettype wire

/* design/gb_glue_top.sv */
// glue logic around the console core, all on clk_sys
// ties the host register file to the reset timer, fast-forward control
// and the LCD-to-video conditioning

`default_nettype none

module gb_glue_top
  import gb_glue_pkg::*;
(
  input  wire           clk_sys,
  input  wire           pll_core_locked,

  // host bridge
  input  wire bridge_req_t bridge,
  output logic [31:0]   bridge_rd_data,

  // fast-forward button and audio path
  input  wire           ff_button,
  input  wire audio_sample_t audio_in,
  output audio_sample_t audio_out,

  // lcd in, video out
  input  wire lcd_in_t  lcd,
  output video_t        video,

  output logic          core_reset
);

  logic      reset_req;
  host_cfg_t cfg;
  palette_t  palette;

  // fast-forward status, kept visible at this level
  logic      fast_forward;

  host_regs i_host_regs (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .rd_data         (bridge_rd_data),
    .reset_req       (reset_req),
    .cfg             (cfg),
    .palette         (palette)
  );

  reset_timer i_reset_timer (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .reset_req       (reset_req),
    .core_reset      (core_reset)
  );

  fast_forward_ctrl i_fast_forward_ctrl (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .ff_button       (ff_button),
    .ff_snd_en       (cfg.ff_snd_en),
    .audio_in        (audio_in),
    .audio_out       (audio_out),
    .fast_forward    (fast_forward)
  );

  video_out i_video_out (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .lcd             (lcd),
    .palette         (palette),
    .gray_en         (cfg.gray_en),
    .video           (video)
  );

endmodule

`default_nettype wire

/* design/host_regs.sv */
// host configuration registers on the bridge bus
// writes apply on the edge that samples wr, reads return one cycle after rd
// and hold until the next read

`default_nettype none

module host_regs
  import gb_glue_pkg::*;
(
  input  wire              clk_sys,
  input  wire              pll_core_locked,
  input  wire bridge_req_t bridge,
  output logic [31:0]      rd_data,
  output logic             reset_req,
  output host_cfg_t        cfg,
  output palette_t         palette
);

  logic        wr_reset;
  logic        wr_ff_snd;
  logic        wr_gray;
  logic        wr_palette;
  logic [31:0] rd_mux;

  //////////////////////////////
  // write decode

  assign wr_reset   = bridge.wr && (bridge.addr == ADDR_RESET_REQ);
  assign wr_ff_snd  = bridge.wr && (bridge.addr == ADDR_FF_SND);
  assign wr_gray    = bridge.wr && (bridge.addr == ADDR_GRAY);
  assign wr_palette = bridge.wr && (bridge.addr == ADDR_PALETTE);

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_req <= 1'b0;
      cfg       <= '0;
      palette   <= PALETTE_DEFAULT;
    end else begin
      // single cycle request toward the reset timer
      reset_req <= wr_reset;

      if (wr_ff_snd) begin
        cfg.ff_snd_en <= bridge.wr_data[0];
      end
      if (wr_gray) begin
        cfg.gray_en <= bridge.wr_data[0];
      end

      // oldest 16 bits fall off the top
      if (wr_palette) begin
        palette <= {palette[79:0], bridge.wr_data[15:0]};
      end
    end
  end

  //////////////////////////////
  // read-back

  always_comb begin
    case (bridge.addr)
      ADDR_FF_SND:  rd_mux = {31'd0, cfg.ff_snd_en};
      ADDR_GRAY:    rd_mux = {31'd0, cfg.gray_en};
      ADDR_PALETTE: rd_mux = {16'd0, palette[15:0]};
      default:      rd_mux = 32'd0;
    endcase
  end

  // holds last read value between reads
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rd_data <= 32'd0;
    end else if (bridge.rd) begin
      rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* design/reset_timer.sv */
// core reset hold timer
// a request loads the hold count, core reset stays high until it runs out
// a request during a hold extends it

`default_nettype none

module reset_timer
  import gb_glue_pkg::*;
(
  input  wire  clk_sys,
  input  wire  pll_core_locked,
  input  wire  reset_req,
  output logic core_reset
);

  logic [31:0] hold_cnt;

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= 32'd0;
    end else if (reset_req) begin
      // reload, so back-to-back requests stretch the hold
      hold_cnt <= RESET_HOLD_CYCLES;
    end else if (hold_cnt != 32'd0) begin
      hold_cnt <= hold_cnt - 32'd1;
    end
  end

  // high for exactly RESET_HOLD_CYCLES after the last request
  assign core_reset = (hold_cnt != 32'd0);

endmodule

`default_nettype wire

/* gb_glue_top.f */
+incdir+tb
common/gb_glue_pkg.sv
design/host_regs.sv
design/reset_timer.sv
design/fast_forward_ctrl.sv
video/video_out.sv
design/gb_glue_top.sv
tb/gb_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the glue logic testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module gb_glue_tb -f gb_glue_top.f -o gb_glue_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/gb_glue_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation run returned an error, see sim.log"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL, see sim.log"
exit 1

/* tb/gb_glue_model.svh */
// reference model for the glue logic testbench, included inside the testbench module
// model_step runs at each rising edge after reset and sets the exp_ values
// for the cycle that edge starts

`ifndef GB_GLUE_MODEL_SVH
`define GB_GLUE_MODEL_SVH

localparam int CYC_START = 16;
localparam int HIST      = 16;

// video inputs and settings seen during one cycle
typedef struct packed {
  lcd_in_t     lcd;
  logic        hs_rise;
  logic        vs_rise;
  logic [95:0] pal;
  logic        gray;
} vid_hist_t;

vid_hist_t     hist [HIST];
int            cyc;
int            last_rst_wr;
int            ff_cnt;
ff_state_e     m_ff;
host_cfg_t     m_cfg;
logic [95:0]   m_pal;
logic          exp_core_reset;
logic          exp_ff;
logic [31:0]   exp_rd;
audio_sample_t exp_audio;
video_t        exp_video;

function automatic logic [23:0] pal_color(input logic [95:0] pal, input logic [1:0] shade);
  // color 0 in the top 24 bits
  return pal[95 - 24 * int'(shade) -: 24];
endfunction

function automatic logic [7:0] luma(input logic [23:0] c);
  return (c[23:16] >> 2) + (c[23:16] >> 5) + (c[15:8] >> 1) + (c[15:8] >> 4)
       + (c[7:0] >> 4) + (c[7:0] >> 5);
endfunction

function automatic logic [31:0] reg_value(input logic [31:0] addr);
  case (addr)
    ADDR_FF_SND:  return {31'd0, m_cfg.ff_snd_en};
    ADDR_GRAY:    return {31'd0, m_cfg.gray_en};
    ADDR_PALETTE: return {16'd0, m_pal[15:0]};
    default:      return 32'd0;
  endcase
endfunction

task automatic model_reset();
  cyc            = CYC_START;
  last_rst_wr    = -1000;
  ff_cnt         = 0;
  m_ff           = FF_OFF;
  m_cfg          = '0;
  m_pal          = PALETTE_DEFAULT;
  exp_core_reset = 1'b0;
  exp_ff         = 1'b0;
  exp_rd         = 32'd0;
  exp_audio      = '0;
  exp_video      = '0;
  for (int i = 0; i < HIST; i++) begin
    hist[i] = '0;
  end
endtask

task automatic model_step();
  vid_hist_t cur;
  vid_hist_t old;
  logic      hs_pend;
  int        hs_d;
  hs_d = int'(HS_DELAY);
  cyc++;
  // log the cycle that just ended
  cur.lcd     = lcd;
  cur.hs_rise = lcd.hsync && !hist[(cyc - 2) % HIST].lcd.hsync;
  cur.vs_rise = lcd.vsync && !hist[(cyc - 2) % HIST].lcd.vsync;
  cur.pal     = m_pal;
  cur.gray    = m_cfg.gray_en;
  hist[(cyc - 1) % HIST] = cur;

  // pixel from two cycles back, grayscale switch from one cycle back
  old           = hist[(cyc - 2) % HIST];
  exp_video.de  = !(old.lcd.hblank || old.lcd.vblank);
  exp_video.rgb = exp_video.de ? pal_color(old.pal, old.lcd.shade) : 24'd0;
  if (cur.gray) begin
    exp_video.rgb = {3{luma(exp_video.rgb)}};
  end
  exp_video.vs = old.vs_rise;
  // hs needs a rise 2+HS_DELAY back and no newer one before the pulse
  hs_pend = hist[(cyc - 2 - hs_d) % HIST].hs_rise;
  for (int i = cyc - 1 - hs_d; i < cyc - 1; i++) begin
    hs_pend = hs_pend && !hist[i % HIST].hs_rise;
  end
  exp_video.hs = hs_pend;

  if (m_ff != FF_OFF && !m_cfg.ff_snd_en) begin
    exp_audio = '0;
  end else begin
    exp_audio = audio_in;
  end

  // hold runs from two cycles after the write
  exp_core_reset = (cyc <= last_rst_wr + 1 + int'(RESET_HOLD_CYCLES));
  if (bridge.rd) begin
    exp_rd = reg_value(bridge.addr);
  end
  if (bridge.wr) begin
    case (bridge.addr)
      ADDR_RESET_REQ: last_rst_wr = cyc - 1;
      ADDR_FF_SND:    m_cfg.ff_snd_en = bridge.wr_data[0];
      ADDR_GRAY:      m_cfg.gray_en = bridge.wr_data[0];
      ADDR_PALETTE:   m_pal = {m_pal[79:0], bridge.wr_data[15:0]};
      default:        ;
    endcase
  end

  case (m_ff)
    FF_OFF: begin
      if (ff_button) begin
        m_ff   = FF_HOLD;
        ff_cnt = 0;
      end
    end
    FF_HOLD: begin
      if (!ff_button) begin
        m_ff = (ff_cnt < int'(TAP_LIMIT)) ? FF_LATCHED : FF_OFF;
      end else begin
        ff_cnt++;
      end
    end
    FF_LATCHED: begin
      if (ff_button) begin
        m_ff = FF_UNLATCH_HOLD;
      end
    end
    default: begin
      if (!ff_button) begin
        m_ff = FF_OFF;
      end
    end
  endcase
  exp_ff = (m_ff != FF_OFF);
endtask

`endif

/* tb/gb_glue_tb.sv */
// testbench for the console glue logic
// random bus, button, audio and LCD stimulus from a fixed seed, all outputs
// compared every cycle against the model in gb_glue_model.svh

`default_nettype none

module gb_glue_tb
  import gb_glue_pkg::*;
();

  localparam int N_REG      = 200;
  localparam int N_PRESS    = 30;
  localparam int N_VID      = 600;
  localparam int HOLD_LIMIT = 200;
  // longest press is 40 cycles plus a gap of up to 10
  localparam int TOTAL_CYCLES = 10 + N_REG + 2 * HOLD_LIMIT + N_PRESS * 50 + N_VID;

  logic          clk_sys;
  logic          pll_core_locked;
  bridge_req_t   bridge;
  logic [31:0]   bridge_rd_data;
  logic          ff_button;
  audio_sample_t audio_in;
  audio_sample_t audio_out;
  lcd_in_t       lcd;
  video_t        video;
  logic          core_reset;

  int            err_count;
  int            check_count;
  int            test_errs;

  `include "gb_glue_model.svh"

  gb_glue_top i_dut (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .bridge_rd_data  (bridge_rd_data),
    .ff_button       (ff_button),
    .audio_in        (audio_in),
    .audio_out       (audio_out),
    .lcd             (lcd),
    .video           (video),
    .core_reset      (core_reset)
  );

  always #4 clk_sys = ~clk_sys;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_outputs();
    check_value("core_reset", 32'(core_reset), 32'(exp_core_reset));
    check_value("fast_forward", 32'(i_dut.fast_forward), 32'(exp_ff));
    check_value("bridge_rd_data", bridge_rd_data, exp_rd);
    check_value("audio_out", audio_out, exp_audio);
    // pipeline holds reset leftovers for two cycles
    if (cyc >= CYC_START + 2) begin
      check_value("video.rgb", 32'(video.rgb), 32'(exp_video.rgb));
      check_value("video.de", 32'(video.de), 32'(exp_video.de));
      check_value("video.hs", 32'(video.hs), 32'(exp_video.hs));
      check_value("video.vs", 32'(video.vs), 32'(exp_video.vs));
    end
  endtask

  // model steps at the edge, outputs compared once settled
  task automatic tick();
    @(posedge clk_sys);
    model_step();
    #1;
    check_outputs();
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bridge.wr      = 1'b1;
    bridge.addr    = addr;
    bridge.wr_data = data;
    tick();
    bridge = '0;
  endtask

  task automatic random_bus_op();
    case ($urandom_range(0, 4))
      0:       bridge.addr = ADDR_FF_SND;
      1:       bridge.addr = ADDR_GRAY;
      2:       bridge.addr = ADDR_PALETTE;
      3:       bridge.addr = ADDR_RESET_REQ;
      default: bridge.addr = $urandom();
    endcase
    bridge.wr      = ($urandom_range(0, 2) == 0);
    bridge.rd      = ($urandom_range(0, 1) == 0);
    bridge.wr_data = $urandom();
  endtask

  task automatic check_hold(input int second_at);
    int high_cnt;
    int waited;
    int expect_len;
    high_cnt   = 0;
    waited     = 0;
    // a second request d cycles after the first stretches the hold by d
    expect_len = int'(RESET_HOLD_CYCLES) + ((second_at > 0) ? second_at + 1 : 0);
    bus_write(ADDR_RESET_REQ, $urandom());
    while (waited < HOLD_LIMIT && !(high_cnt > 0 && !core_reset)) begin
      if (second_at > 0 && waited == second_at) begin
        bus_write(ADDR_RESET_REQ, $urandom());
      end else begin
        tick();
      end
      if (core_reset) begin
        high_cnt++;
      end
      waited++;
    end
    assert (waited < HOLD_LIMIT) else begin
      $display("core_reset never dropped after a reset request, time %0t", $time);
      err_count++;
    end
    check_value("core_reset hold length", high_cnt, expect_len);
  endtask

  task automatic press_button(input int len, input int gap);
    if ($urandom_range(0, 2) == 0) begin
      bridge.wr      = 1'b1;
      bridge.addr    = ADDR_FF_SND;
      bridge.wr_data = $urandom();
    end
    ff_button = 1'b1;
    for (int i = 0; i < len + gap; i++) begin
      if (i == len) begin
        ff_button = 1'b0;
      end
      audio_in = $urandom();
      tick();
      bridge = '0;
    end
  endtask

  task automatic drive_lcd();
    lcd.shade  = 2'($urandom_range(0, 3));
    lcd.hblank = ($urandom_range(0, 3) == 0);
    lcd.vblank = ($urandom_range(0, 7) == 0);
    // syncs toggle now and then, so rising edges come at random spacing
    if ($urandom_range(0, 5) == 0) begin
      lcd.hsync = !lcd.hsync;
    end
    if ($urandom_range(0, 9) == 0) begin
      lcd.vsync = !lcd.vsync;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %0d errors", name, err_count - test_errs);
    test_errs = err_count;
  endtask

  initial begin
    void'($urandom(37103));
    clk_sys         = 1'b0;
    pll_core_locked = 1'b0;
    bridge          = '0;
    ff_button       = 1'b0;
    audio_in        = '0;
    lcd             = '0;
    err_count       = 0;
    check_count     = 0;
    test_errs       = 0;
    model_reset();
    repeat (2) @(posedge clk_sys);
    #1;
    pll_core_locked = 1'b1;

    check_value("core_reset after reset", 32'(core_reset), 32'd0);
    check_value("fast_forward after reset", 32'(i_dut.fast_forward), 32'd0);
    check_value("video sync and de after reset", {29'd0, video.de, video.hs, video.vs}, 32'd0);
    check_value("audio_out after reset", audio_out, 32'd0);
    check_value("bridge_rd_data after reset", bridge_rd_data, 32'd0);
    bridge.rd   = 1'b1;
    bridge.addr = ADDR_PALETTE;
    tick();
    bridge = '0;
    check_value("palette read after reset", bridge_rd_data, 32'h0000_3B49);
    finish_test("reset_values");

    for (int i = 0; i < N_REG; i++) begin
      random_bus_op();
      tick();
    end
    bridge = '0;
    tick();
    finish_test("registers");

    check_hold(0);
    check_hold(19);
    finish_test("reset_hold");

    for (int p = 0; p < N_PRESS; p++) begin
      press_button(int'(TAP_LIMIT) - 8 + int'($urandom_range(0, 16)),
                   int'($urandom_range(1, 10)));
    end
    finish_test("fast_forward");

    for (int i = 0; i < N_VID; i++) begin
      drive_lcd();
      if ($urandom_range(0, 15) == 0) begin
        bridge.wr      = 1'b1;
        bridge.addr    = ($urandom_range(0, 3) == 0) ? ADDR_GRAY : ADDR_PALETTE;
        bridge.wr_data = $urandom();
      end
      tick();
      bridge = '0;
    end
    finish_test("video");

    $display("all tests done: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the test lengths
  initial begin
    #(TOTAL_CYCLES * 8 + 400);
    $display("watchdog expired at %0t before the tests finished", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* video/video_out.sv */
// LCD shade to 24-bit video conditioning, two pipeline stages
// stage one: palette lookup, data enable, sync edge detect
// stage two: optional grayscale, single-cycle vsync, delayed hsync pulse

`default_nettype none

module video_out
  import gb_glue_pkg::*;
(
  input  wire          clk_sys,
  input  wire          pll_core_locked,
  input  wire lcd_in_t lcd,
  input  wire palette_t palette,
  input  wire          gray_en,
  output video_t       video
);

  logic        de_in;
  logic [23:0] shade_rgb;
  logic        hs_prev;
  logic        vs_prev;

  // stage one
  logic        de_s1;
  logic [23:0] rgb_s1;
  logic        hs_rise_s1;
  logic        vs_rise_s1;

  // stage two
  logic [7:0]  lum;
  logic [2:0]  hs_cnt;
  logic        de_s2;
  logic        hs_s2;
  logic        vs_s2;
  logic [23:0] rgb_s2;

  //////////////////////////////
  // stage one

  assign de_in = !(lcd.hblank || lcd.vblank);

  always_comb begin
    case (lcd.shade)
      2'd0:    shade_rgb = palette.color0;
      2'd1:    shade_rgb = palette.color1;
      2'd2:    shade_rgb = palette.color2;
      default: shade_rgb = palette.color3;
    endcase
  end

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_s1      <= 1'b0;
      hs_prev    <= 1'b0;
      vs_prev    <= 1'b0;
      hs_rise_s1 <= 1'b0;
      vs_rise_s1 <= 1'b0;
    end else begin
      de_s1      <= de_in;
      hs_prev    <= lcd.hsync;
      vs_prev    <= lcd.vsync;
      hs_rise_s1 <= lcd.hsync && !hs_prev;
      vs_rise_s1 <= lcd.vsync && !vs_prev;
    end
  end

  // black outside the active area
  always_ff @(posedge clk_sys) begin
    rgb_s1 <= de_in ? shade_rgb : 24'd0;
  end

  //////////////////////////////
  // stage two

  // luma approximation, sum truncated to 8 bits
  assign lum = (rgb_s1[23:16] >> 2) + (rgb_s1[23:16] >> 5)
             + (rgb_s1[15:8] >> 1) + (rgb_s1[15:8] >> 4)
             + (rgb_s1[7:0] >> 4) + (rgb_s1[7:0] >> 5);

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_s2  <= 1'b0;
      vs_s2  <= 1'b0;
      hs_s2  <= 1'b0;
      hs_cnt <= 3'd0;
    end else begin
      de_s2 <= de_s1;
      vs_s2 <= vs_rise_s1;
      // a new hsync edge restarts the delay and drops any pending pulse
      hs_s2 <= (hs_cnt == 3'd1) && !hs_rise_s1;
      if (hs_rise_s1) begin
        hs_cnt <= HS_DELAY;
      end else if (hs_cnt != 3'd0) begin
        hs_cnt <= hs_cnt - 3'd1;
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    rgb_s2 <= gray_en ? {lum, lum, lum} : rgb_s1;
  end

  assign video.rgb = rgb_s2;
  assign video.de  = de_s2;
  assign video.hs  = hs_s2;
  assign video.vs  = vs_s2;

endmodule

`default_nettype wire
